// File: verilog/host_protocol_pkg.sv
package host_protocol_pkg;

	// Width of one word on the host receive port.
	localparam int HOST_WORD_WIDTH = 64;

	////////////////////
	// Command codes
	////////////////////

	// Command byte, carried in the low byte of a header word.
	typedef enum logic [7:0] {
		CMD_STORE_VECTOR = 8'hA1,
		CMD_CYCLE_CONFIG = 8'hA2,
		CMD_EXECUTE      = 8'hA3
	} host_cmd_e;

	////////////////////
	// Response codes
	////////////////////

	typedef enum logic [7:0] {
		RESP_ACK         = 8'h5A,
		RESP_UNKNOWN     = 8'hE1,
		RESP_NO_VECTORS  = 8'hE2,
		RESP_MEMORY_FULL = 8'hE3
	} resp_code_e;

	// Field positions within a host word.
	localparam int CMD_LSB   = 0;
	localparam int LEAD_LSB  = 8;
	localparam int TRAIL_LSB = 16;
	localparam int LEN_LSB   = 24;

endpackage

// File: verilog/test_cycle_pkg.sv
package test_cycle_pkg;

	////////////////////
	// Cycle timing
	////////////////////

	// Width of the leading edge, trailing edge and cycle length fields.
	// The cycle counter uses the same width.
	localparam int EDGE_WIDTH = 8;

	////////////////////
	// Vector storage
	////////////////////

	// Bits applied to the signal bus per test cycle.
	localparam int DEFAULT_VECTOR_WIDTH = 32;

	// Number of vectors the on-chip memory holds.
	localparam int DEFAULT_VECTOR_DEPTH = 16;

endpackage

// File: verilog/vector_memory.sv
`timescale 1ns/1ps

module vector_memory #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH,
	parameter int vector_depth = test_cycle_pkg::DEFAULT_VECTOR_DEPTH,
	localparam int addr_width = $clog2(vector_depth),
	localparam int count_width = $clog2(vector_depth + 1)
) (
	input  logic                    CLK,
	input  logic                    rst,
	input  logic                    wr_en,
	input  logic [vector_width-1:0] wr_data,
	input  logic                    rd_en,
	input  logic [addr_width-1:0]   rd_addr,
	output logic [vector_width-1:0] rd_data,
	output logic [count_width-1:0]  vector_count,
	output logic                    full,
	output logic                    empty
);

	logic [vector_width-1:0] mem [vector_depth];
	logic [count_width-1:0]  wr_ptr;

	// The write pointer is the number of stored vectors.
	assign vector_count = wr_ptr;
	assign full = (wr_ptr == count_width'(vector_depth));
	assign empty = (wr_ptr == '0);

	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
		end
		else if (wr_en) begin
			wr_ptr <= wr_ptr + count_width'(1);
		end
	end

	// Storage array and registered read port.
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_ptr[addr_width-1:0]] <= wr_data;
		end
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: verilog/command_sequencer.sv
`timescale 1ns/1ps

module command_sequencer #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH,
	parameter int vector_depth = test_cycle_pkg::DEFAULT_VECTOR_DEPTH,
	localparam int count_width = $clog2(vector_depth + 1)
) (
	input  logic                                      CLK,
	input  logic                                      rst,
	input  logic [host_protocol_pkg::HOST_WORD_WIDTH-1:0] host_word,
	input  logic                                      host_valid,
	output logic                                      host_taken,
	output host_protocol_pkg::resp_code_e             resp_code,
	output logic                                      resp_valid,
	input  logic                                      resp_ack,
	output logic                                      wr_en,
	output logic [vector_width-1:0]                   wr_data,
	input  logic [count_width-1:0]                    vector_count,
	input  logic                                      full,
	input  logic                                      empty,
	output logic                                      run_start,
	input  logic                                      run_done,
	output logic [test_cycle_pkg::EDGE_WIDTH-1:0]     lead_edge,
	output logic [test_cycle_pkg::EDGE_WIDTH-1:0]     trail_edge,
	output logic [test_cycle_pkg::EDGE_WIDTH-1:0]     cycle_len
);

	import host_protocol_pkg::*;
	import test_cycle_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DECODE,
		ST_AWAIT_DATA,
		ST_STORE,
		ST_RUN,
		ST_RESPOND,
		ST_WAIT_ACK
	} seq_state_e;

	seq_state_e                 state;
	logic [HOST_WORD_WIDTH-1:0] cmd_word;
	host_cmd_e                  cmd_byte;
	logic                       data_next;
	logic [count_width-1:0]     count_snap;

	// A word is consumed only while waiting for a header or a data word.
	assign host_taken = host_valid && ((state == ST_IDLE) || (state == ST_AWAIT_DATA));

	assign cmd_byte = host_cmd_e'(cmd_word[CMD_LSB +: 8]);

	// Captured host words.
	always_ff @(posedge CLK) begin
		if (host_taken && (state == ST_IDLE)) begin
			cmd_word <= host_word;
		end
		if (host_taken && (state == ST_AWAIT_DATA)) begin
			wr_data <= host_word[vector_width-1:0];
			// Count before the write, so the store can see it land.
			count_snap <= vector_count;
		end
	end

	////////////////////
	// Main FSM
	////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= ST_IDLE;
			resp_valid <= 1'b0;
			resp_code <= RESP_ACK;
			data_next <= 1'b0;
			wr_en <= 1'b0;
			run_start <= 1'b0;
			lead_edge <= '0;
			trail_edge <= '0;
			cycle_len <= '0;
		end
		else begin
			wr_en <= 1'b0;
			run_start <= 1'b0;

			case (state)
				ST_IDLE: begin
					if (host_valid) begin
						state <= ST_DECODE;
					end
				end

				ST_DECODE: begin
					data_next <= 1'b0;
					state <= ST_RESPOND;
					case (cmd_byte)
						CMD_STORE_VECTOR: begin
							if (full) begin
								resp_code <= RESP_MEMORY_FULL;
							end
							else begin
								// Header accepted, the data word follows the ack.
								resp_code <= RESP_ACK;
								data_next <= 1'b1;
							end
						end
						CMD_CYCLE_CONFIG: begin
							lead_edge <= cmd_word[LEAD_LSB +: EDGE_WIDTH];
							trail_edge <= cmd_word[TRAIL_LSB +: EDGE_WIDTH];
							cycle_len <= cmd_word[LEN_LSB +: EDGE_WIDTH];
							resp_code <= RESP_ACK;
						end
						CMD_EXECUTE: begin
							if (empty) begin
								resp_code <= RESP_NO_VECTORS;
							end
							else begin
								run_start <= 1'b1;
								state <= ST_RUN;
							end
						end
						default: begin
							resp_code <= RESP_UNKNOWN;
						end
					endcase
				end

				ST_AWAIT_DATA: begin
					if (host_valid) begin
						wr_en <= 1'b1;
						data_next <= 1'b0;
						state <= ST_STORE;
					end
				end

				ST_STORE: begin
					// Wait for the write pointer to move.
					if (vector_count != count_snap) begin
						resp_code <= RESP_ACK;
						state <= ST_RESPOND;
					end
				end

				ST_RUN: begin
					if (run_done) begin
						resp_code <= RESP_ACK;
						state <= ST_RESPOND;
					end
				end

				ST_RESPOND: begin
					resp_valid <= 1'b1;
					state <= ST_WAIT_ACK;
				end

				ST_WAIT_ACK: begin
					// Host may hold off the ack for as long as it likes.
					if (resp_ack) begin
						resp_valid <= 1'b0;
						state <= data_next ? ST_AWAIT_DATA : ST_IDLE;
					end
				end

				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog/cycle_generator.sv
`timescale 1ns/1ps

module cycle_generator #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH,
	parameter int vector_depth = test_cycle_pkg::DEFAULT_VECTOR_DEPTH,
	localparam int addr_width = $clog2(vector_depth),
	localparam int count_width = $clog2(vector_depth + 1)
) (
	input  logic                                  CLK,
	input  logic                                  rst,
	input  logic                                  run_start,
	input  logic [test_cycle_pkg::EDGE_WIDTH-1:0] lead_edge,
	input  logic [test_cycle_pkg::EDGE_WIDTH-1:0] trail_edge,
	input  logic [test_cycle_pkg::EDGE_WIDTH-1:0] cycle_len,
	input  logic [count_width-1:0]                vector_count,
	output logic                                  rd_en,
	output logic [addr_width-1:0]                 rd_addr,
	input  logic [vector_width-1:0]               rd_data,
	output logic [vector_width-1:0]               signals,
	output logic                                  test_active,
	output logic                                  sample_window,
	output logic                                  addr_advance,
	output logic                                  run_done
);

	import test_cycle_pkg::*;

	typedef enum logic [1:0] {
		GEN_IDLE,
		GEN_PREFETCH,
		GEN_APPLY
	} gen_state_e;

	gen_state_e             state;
	logic [EDGE_WIDTH-1:0]  cnt;
	logic [EDGE_WIDTH-1:0]  cnt_next;
	logic [count_width-1:0] vec_idx;
	logic [count_width-1:0] next_idx;
	logic                   boundary;
	logic                   last_vec;
	logic                   window_next;
	logic                   advance_next;

	assign boundary = (cnt == cycle_len);
	assign last_vec = (vec_idx == vector_count - count_width'(1));
	assign next_idx = vec_idx + count_width'(1);

	// Counter value for the next clock; a new cycle starts at zero.
	assign cnt_next = ((state == GEN_APPLY) && !boundary) ? cnt + 1'b1 : '0;
	assign window_next = (cnt_next >= lead_edge) && (cnt_next < trail_edge);
	assign advance_next = (cnt_next == cycle_len);

	////////////////////
	// Vector fetch
	////////////////////

	// First vector on run_start, later ones on count 1 of the current cycle.
	assign rd_en = ((state == GEN_IDLE) && run_start) ||
		((state == GEN_APPLY) && (cnt == EDGE_WIDTH'(1)) && !last_vec);
	assign rd_addr = (state == GEN_IDLE) ? '0 : next_idx[addr_width-1:0];

	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= GEN_IDLE;
			cnt <= '0;
			vec_idx <= '0;
			signals <= '0;
			test_active <= 1'b0;
			sample_window <= 1'b0;
			addr_advance <= 1'b0;
			run_done <= 1'b0;
		end
		else begin
			run_done <= 1'b0;
			case (state)
				GEN_IDLE: begin
					if (run_start) begin
						vec_idx <= '0;
						state <= GEN_PREFETCH;
					end
				end

				GEN_PREFETCH: begin
					// First vector is on rd_data now.
					signals <= rd_data;
					test_active <= 1'b1;
					cnt <= cnt_next;
					sample_window <= window_next;
					addr_advance <= advance_next;
					state <= GEN_APPLY;
				end

				GEN_APPLY: begin
					if (boundary && last_vec) begin
						// End of run, bus back to zero.
						signals <= '0;
						test_active <= 1'b0;
						sample_window <= 1'b0;
						addr_advance <= 1'b0;
						cnt <= '0;
						run_done <= 1'b1;
						state <= GEN_IDLE;
					end
					else begin
						if (boundary) begin
							signals <= rd_data;
							vec_idx <= next_idx;
						end
						cnt <= cnt_next;
						sample_window <= window_next;
						addr_advance <= advance_next;
					end
				end

				default: begin
					state <= GEN_IDLE;
				end
			endcase
		end
	end

endmodule

// File: verilog/vector_tester_top.sv
`timescale 1ns/1ps

module vector_tester_top #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH,
	parameter int vector_depth = test_cycle_pkg::DEFAULT_VECTOR_DEPTH
) (
	input  logic                                      CLK,
	input  logic                                      rst,
	input  logic [host_protocol_pkg::HOST_WORD_WIDTH-1:0] host_word,
	input  logic                                      host_valid,
	output logic                                      host_taken,
	output host_protocol_pkg::resp_code_e             resp_code,
	output logic                                      resp_valid,
	input  logic                                      resp_ack,
	output logic [vector_width-1:0]                   signals,
	output logic                                      test_active,
	output logic                                      sample_window,
	output logic                                      addr_advance
);

	import test_cycle_pkg::*;

	localparam int addr_width = $clog2(vector_depth);
	localparam int count_width = $clog2(vector_depth + 1);

	// Sequencer to memory.
	logic                    wr_en;
	logic [vector_width-1:0] wr_data;
	logic [count_width-1:0]  vector_count;
	logic                    full;
	logic                    empty;

	// Generator to memory.
	logic                    rd_en;
	logic [addr_width-1:0]   rd_addr;
	logic [vector_width-1:0] rd_data;

	// Sequencer to generator.
	logic                    run_start;
	logic                    run_done;
	logic [EDGE_WIDTH-1:0]   lead_edge;
	logic [EDGE_WIDTH-1:0]   trail_edge;
	logic [EDGE_WIDTH-1:0]   cycle_len;

	command_sequencer #(
		.vector_width(vector_width),
		.vector_depth(vector_depth)
	) u_command_sequencer (
		.CLK(CLK),
		.rst(rst),
		.host_word(host_word),
		.host_valid(host_valid),
		.host_taken(host_taken),
		.resp_code(resp_code),
		.resp_valid(resp_valid),
		.resp_ack(resp_ack),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.vector_count(vector_count),
		.full(full),
		.empty(empty),
		.run_start(run_start),
		.run_done(run_done),
		.lead_edge(lead_edge),
		.trail_edge(trail_edge),
		.cycle_len(cycle_len)
	);

	vector_memory #(
		.vector_width(vector_width),
		.vector_depth(vector_depth)
	) u_vector_memory (
		.CLK(CLK),
		.rst(rst),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.vector_count(vector_count),
		.full(full),
		.empty(empty)
	);

	cycle_generator #(
		.vector_width(vector_width),
		.vector_depth(vector_depth)
	) u_cycle_generator (
		.CLK(CLK),
		.rst(rst),
		.run_start(run_start),
		.lead_edge(lead_edge),
		.trail_edge(trail_edge),
		.cycle_len(cycle_len),
		.vector_count(vector_count),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.signals(signals),
		.test_active(test_active),
		.sample_window(sample_window),
		.addr_advance(addr_advance),
		.run_done(run_done)
	);

endmodule

// File: verif/cycle_generator_assertions.sv
`timescale 1ns/1ps

module cycle_generator_assertions #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH
) (
	input logic                    CLK,
	input logic                    rst,
	input logic [vector_width-1:0] signals,
	input logic                    test_active,
	input logic                    sample_window,
	input logic                    addr_advance
);

	// Strobe and window only appear inside a run.
	advance_in_run: assert property (@(posedge CLK) disable iff (rst)
		addr_advance |-> test_active)
		else $error("addr_advance high outside a run");

	window_in_run: assert property (@(posedge CLK) disable iff (rst)
		sample_window |-> test_active)
		else $error("sample_window high outside a run");

	// The bus rests at zero between runs.
	idle_bus_zero: assert property (@(posedge CLK) disable iff (rst)
		!test_active |-> (signals == '0))
		else $error("signals not zero outside a run");

endmodule

bind cycle_generator cycle_generator_assertions #(
	.vector_width(vector_width)
) u_cycle_generator_assertions (
	.CLK(CLK),
	.rst(rst),
	.signals(signals),
	.test_active(test_active),
	.sample_window(sample_window),
	.addr_advance(addr_advance)
);

// File: verif/vector_tester_checker.sv
`timescale 1ns/1ps

module vector_tester_checker #(
	parameter int vector_width = test_cycle_pkg::DEFAULT_VECTOR_WIDTH,
	parameter int vector_depth = test_cycle_pkg::DEFAULT_VECTOR_DEPTH
) (
	input  logic                                          CLK,
	input  logic                                          rst,
	input  logic [host_protocol_pkg::HOST_WORD_WIDTH-1:0] host_word,
	input  logic                                          host_valid,
	input  logic                                          host_taken,
	input  host_protocol_pkg::resp_code_e                 resp_code,
	input  logic                                          resp_valid,
	input  logic                                          resp_ack,
	input  logic [vector_width-1:0]                       signals,
	input  logic                                          test_active,
	input  logic                                          sample_window,
	input  logic                                          addr_advance,
	input  logic                                          test_done,
	input  int                                            test_id,
	output int                                            error_count,
	output int                                            tests_passed,
	output int                                            tests_failed
);

	import host_protocol_pkg::*;
	import test_cycle_pkg::*;

	// Model of what the DUT should hold, built from the words it took.
	logic [vector_width-1:0] model_mem [vector_depth];
	int                      model_count;
	int                      lead;
	int                      trail;
	int                      len;
	logic                    expect_data;
	logic                    run_pending;
	logic                    in_run;
	int                      vec_i;
	int                      cyc;
	resp_code_e              expected_q [$];
	resp_code_e              expected;
	int                      errors = 0;
	int                      test_errors = 0;
	int                      passed = 0;
	int                      failed = 0;

	assign error_count = errors;
	assign tests_passed = passed;
	assign tests_failed = failed;

	function automatic string test_name(input int id);
		case (id)
			1: test_name = "execute with empty memory";
			2: test_name = "unknown command";
			3: test_name = "fill memory";
			4: test_name = "first run";
			5: test_name = "replay with new timing";
			default: test_name = "unnamed";
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp_val, act_val);
		errors++;
		test_errors++;
	endtask

	task automatic report_problem(input string what);
		$display("Error at %0t: %s", $time, what);
		errors++;
		test_errors++;
	endtask

	always @(posedge CLK) begin
		if (rst) begin
			model_count = 0;
			{lead, trail, len} = '0;
			expect_data = 1'b0;
			run_pending = 1'b0;
			in_run = 1'b0;
			expected_q.delete();
		end
		else begin
			////////////////////
			// Word intake
			////////////////////
			if (host_valid && host_taken) begin
				if (expect_data) begin
					model_mem[model_count] = host_word[vector_width-1:0];
					model_count++;
					expect_data = 1'b0;
					expected_q.push_back(RESP_ACK);
				end
				else begin
					case (host_word[CMD_LSB +: 8])
						CMD_STORE_VECTOR: begin
							if (model_count == vector_depth) begin
								expected_q.push_back(RESP_MEMORY_FULL);
							end
							else begin
								expected_q.push_back(RESP_ACK);
								expect_data = 1'b1;
							end
						end
						CMD_CYCLE_CONFIG: begin
							lead = host_word[LEAD_LSB +: EDGE_WIDTH];
							trail = host_word[TRAIL_LSB +: EDGE_WIDTH];
							len = host_word[LEN_LSB +: EDGE_WIDTH];
							expected_q.push_back(RESP_ACK);
						end
						CMD_EXECUTE: begin
							if (model_count == 0) begin
								expected_q.push_back(RESP_NO_VECTORS);
							end
							else begin
								run_pending = 1'b1;
								expected_q.push_back(RESP_ACK);
							end
						end
						default: expected_q.push_back(RESP_UNKNOWN);
					endcase
				end
			end

			// Responses, in command order.
			if (resp_valid && resp_ack) begin
				if (expected_q.size() == 0) begin
					report_problem("response arrived with no command outstanding");
				end
				else begin
					expected = expected_q.pop_front();
					if (resp_code !== expected) begin
						report_mismatch("resp_code", expected, resp_code);
					end
					if (run_pending || in_run) begin
						report_problem("response arrived before the run finished");
					end
				end
			end

			////////////////////
			// Run waveform
			////////////////////
			if (test_active) begin
				if (!in_run) begin
					if (!run_pending) begin
						report_problem("test_active rose without an execute command");
					end
					in_run = 1'b1;
					run_pending = 1'b0;
					vec_i = 0;
					cyc = 0;
				end
				if (vec_i >= model_count) begin
					report_problem("test_active held past the last vector");
				end
				else begin
					if (signals !== model_mem[vec_i]) begin
						report_mismatch("signals", model_mem[vec_i], signals);
					end
					if (sample_window !== (cyc >= lead && cyc < trail)) begin
						report_mismatch("sample_window", (cyc >= lead && cyc < trail),
							sample_window);
					end
					if (addr_advance !== (cyc == len)) begin
						report_mismatch("addr_advance", (cyc == len), addr_advance);
					end
				end
				cyc++;
				if (cyc > len) begin
					cyc = 0;
					vec_i++;
				end
			end
			else begin
				if (in_run) begin
					in_run = 1'b0;
					if (vec_i != model_count) begin
						report_mismatch("vectors applied", model_count, vec_i);
					end
				end
				// Outputs idle between runs.
				if (signals !== '0) begin
					report_mismatch("signals", '0, signals);
				end
				if (sample_window !== 1'b0) begin
					report_mismatch("sample_window", 1'b0, sample_window);
				end
				if (addr_advance !== 1'b0) begin
					report_mismatch("addr_advance", 1'b0, addr_advance);
				end
			end

			if (test_done) begin
				if (expected_q.size() != 0) begin
					report_problem("responses still outstanding at the end of the test");
				end
				if (test_errors == 0) begin
					passed++;
					$display("Test %0d %s: passed", test_id, test_name(test_id));
				end
				else begin
					failed++;
					$display("Test %0d %s: failed with %0d errors", test_id,
						test_name(test_id), test_errors);
				end
				test_errors = 0;
			end
		end
	end

endmodule

// File: verif/tb_vector_tester.sv
`timescale 1ns/1ps

module tb_vector_tester;

	import host_protocol_pkg::*;
	import test_cycle_pkg::*;

	localparam int vector_width = DEFAULT_VECTOR_WIDTH;
	localparam int vector_depth = DEFAULT_VECTOR_DEPTH;

	// Two full runs at the longest cycle, plus headroom for every command.
	localparam int num_commands = 2 + (2 * vector_depth + 1) + 4;
	localparam int timeout_limit = 2 * vector_depth * 256 + 200 * num_commands;

	logic                       CLK = 1'b0;
	logic                       rst;
	logic [HOST_WORD_WIDTH-1:0] host_word;
	logic                       host_valid;
	logic                       host_taken;
	resp_code_e                 resp_code;
	logic                       resp_valid;
	logic                       resp_ack;
	logic [vector_width-1:0]    signals;
	logic                       test_active;
	logic                       sample_window;
	logic                       addr_advance;

	logic   test_done;
	int     test_id;
	int     error_count;
	int     tests_passed;
	int     tests_failed;
	integer seed;
	int     cycle_count = 0;

	always #2 CLK = ~CLK;

	vector_tester_top #(
		.vector_width(vector_width),
		.vector_depth(vector_depth)
	) DUT (
		.CLK(CLK),
		.rst(rst),
		.host_word(host_word),
		.host_valid(host_valid),
		.host_taken(host_taken),
		.resp_code(resp_code),
		.resp_valid(resp_valid),
		.resp_ack(resp_ack),
		.signals(signals),
		.test_active(test_active),
		.sample_window(sample_window),
		.addr_advance(addr_advance)
	);

	vector_tester_checker #(
		.vector_width(vector_width),
		.vector_depth(vector_depth)
	) u_checker (
		.CLK(CLK),
		.rst(rst),
		.host_word(host_word),
		.host_valid(host_valid),
		.host_taken(host_taken),
		.resp_code(resp_code),
		.resp_valid(resp_valid),
		.resp_ack(resp_ack),
		.signals(signals),
		.test_active(test_active),
		.sample_window(sample_window),
		.addr_advance(addr_advance),
		.test_done(test_done),
		.test_id(test_id),
		.error_count(error_count),
		.tests_passed(tests_passed),
		.tests_failed(tests_failed)
	);

	// Hard stop in case the DUT never answers.
	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout: no verdict after %0d clock cycles", cycle_count);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic int unsigned rand_below(input int unsigned n);
		rand_below = $unsigned($random(seed)) % n;
	endfunction

	// Header word with random filler above the command byte.
	function automatic logic [HOST_WORD_WIDTH-1:0] header_word(input logic [7:0] cmd);
		header_word = {$random(seed), $random(seed)};
		header_word[CMD_LSB +: 8] = cmd;
	endfunction

	////////////////////
	// Host model
	////////////////////

	task automatic send_word(input logic [HOST_WORD_WIDTH-1:0] word);
		@(posedge CLK);
		host_word <= word;
		host_valid <= 1'b1;
		do begin
			@(posedge CLK);
		end while (!host_taken);
		host_valid <= 1'b0;
	endtask

	task automatic take_response();
		int unsigned delay;
		do begin
			@(posedge CLK);
		end while (!resp_valid);
		delay = rand_below(6);
		repeat (delay) @(posedge CLK);
		resp_ack <= 1'b1;
		@(posedge CLK);
		resp_ack <= 1'b0;
	endtask

	// Random timing with lead < trail <= len.
	task automatic configure(input int unsigned len_lo, input int unsigned len_span);
		int unsigned len;
		int unsigned lead;
		int unsigned trail;
		len = len_lo + rand_below(len_span);
		lead = rand_below(len);
		trail = lead + 1 + rand_below(len - lead);
		send_word({32'h0, 8'(len), 8'(trail), 8'(lead), CMD_CYCLE_CONFIG});
		take_response();
	endtask

	task automatic execute();
		send_word(header_word(CMD_EXECUTE));
		take_response();
	endtask

	task automatic end_test(input int id);
		@(posedge CLK);
		test_id <= id;
		test_done <= 1'b1;
		@(posedge CLK);
		test_done <= 1'b0;
	endtask

	initial begin
		logic [7:0] cmd;
		seed = 32'h649f6205;
		rst <= 1'b1;
		host_word <= '0;
		host_valid <= 1'b0;
		resp_ack <= 1'b0;
		test_done <= 1'b0;
		test_id <= 0;
		repeat (4) @(posedge CLK);
		rst <= 1'b0;

		// Nothing stored yet.
		execute();
		end_test(1);

		do begin
			cmd = 8'(rand_below(256));
		end while (cmd == CMD_STORE_VECTOR || cmd == CMD_CYCLE_CONFIG || cmd == CMD_EXECUTE);
		send_word(header_word(cmd));
		take_response();
		end_test(2);

		for (int i = 0; i < vector_depth; i++) begin
			send_word(header_word(CMD_STORE_VECTOR));
			take_response();
			send_word({$random(seed), $random(seed)});
			take_response();
		end
		// One header too many.
		send_word(header_word(CMD_STORE_VECTOR));
		take_response();
		end_test(3);

		configure(2, 4);
		execute();
		end_test(4);

		// Longer cycles, so the timing is sure to differ.
		configure(6, 6);
		execute();
		end_test(5);

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
			error_count);
		if (error_count == 0 && tests_failed == 0) begin
			$display("PASS: all tests");
		end
		else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: src.f
verilog/host_protocol_pkg.sv
verilog/test_cycle_pkg.sv
verilog/vector_memory.sv
verilog/command_sequencer.sv
verilog/cycle_generator.sv
verilog/vector_tester_top.sv
verif/cycle_generator_assertions.sv
verif/vector_tester_checker.sv
verif/tb_vector_tester.sv

// File: Bender.yml
package:
  name: vector_tester

sources:
  # Packages first, then the design from the leaves up.
  - verilog/host_protocol_pkg.sv
  - verilog/test_cycle_pkg.sv
  - verilog/vector_memory.sv
  - verilog/command_sequencer.sv
  - verilog/cycle_generator.sv
  - verilog/vector_tester_top.sv

  # Testbench, top module tb_vector_tester.
  - target: test
    files:
      - verif/cycle_generator_assertions.sv
      - verif/vector_tester_checker.sv
      - verif/tb_vector_tester.sv
